// ==== common/core_pkg.sv ====
// Core retire encodings
package core_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths on the writeback side
  ////////////////////////////////////////////////////////////

  // Exception cause as reported with a retire from writeback
  localparam int EXC_CAUSE_W = 6;

  // Interrupt id delivered together with the interrupt acknowledge
  localparam int IRQ_ID_W = 5;

  // Debug entry cause, coded the same way as dcsr.cause
  localparam int DBG_CAUSE_W = 3;

  ////////////////////////////////////////////////////////////
  // Opcodes and causes
  ////////////////////////////////////////////////////////////

  // Kind of instruction leaving the writeback stage
  typedef enum logic [1:0] {
    RET_NORMAL    = 2'd0,
    RET_EXCEPTION = 2'd1,
    RET_DRET      = 2'd2
  } retire_kind_e;

  // Reason for entering debug mode
  // DBG_NONE marks a record without debug entry
  typedef enum logic [DBG_CAUSE_W-1:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_TRIGGER = 3'd2,
    DBG_HALTREQ = 3'd3,
    DBG_STEP    = 3'd4
  } dbg_cause_e;

endpackage

// ==== common/rvfi_pkg.sv ====
// Trace record definitions
package rvfi_pkg;

  ////////////////////////////////////////////////////////////
  // Output handshake
  ////////////////////////////////////////////////////////////

  // States of the four-phase req/ack exchange with the consumer
  // ST_IDLE accepts a retire, ST_REQ holds req high until ack,
  // ST_RELEASE waits for the consumer to drop ack again
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_REQ     = 2'd1,
    ST_RELEASE = 2'd2
  } rvfi_state_e;

  ////////////////////////////////////////////////////////////
  // Record field widths
  ////////////////////////////////////////////////////////////

  // Program counter of the retired instruction
  localparam int PC_W = 32;

  // Interrupt cause field of the record
  // Wide enough for the exception cause and the interrupt id
  localparam int INTR_CAUSE_W = 11;

  // Full width of the mcause shadow
  localparam int MCAUSE_W = 32;

  ////////////////////////////////////////////////////////////
  // mcause layout
  ////////////////////////////////////////////////////////////

  // Interrupt flag of mcause, the code sits in the low bits
  localparam int MCAUSE_IRQ_BIT = 31;

endpackage

// ==== rvfi/rvfi_ctrl.sv ====
`timescale 1ns/1ps
// Retire acceptance and output handshake
module rvfi_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  // Writeback stage
  input  logic wb_valid_i,
  output logic wb_ready_o,

  // Load strobe for the datapath blocks
  output logic accept_o,

  // Trace consumer
  output logic rvfi_req_o,
  input  logic rvfi_ack_i
);

  import rvfi_pkg::*;

  rvfi_state_e state_q;
  rvfi_state_e state_d;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  // One record is in flight at a time
  // A retire is only taken while the previous exchange is fully closed
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Record gets loaded at this edge, req follows one cycle later
        if (accept_o) begin
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        // Consumer has taken the record
        if (rvfi_ack_i) begin
          state_d = ST_RELEASE;
        end
      end
      ST_RELEASE: begin
        // Record must stay stable until ack is seen low
        if (!rvfi_ack_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Back-pressure towards the core while an exchange is open
  assign wb_ready_o = (state_q == ST_IDLE);

  // Every datapath register loads on this strobe
  assign accept_o = wb_valid_i && wb_ready_o;

  // Decoded from the state register, so req never glitches
  assign rvfi_req_o = (state_q == ST_REQ);

endmodule

// ==== rvfi/rvfi_event_track.sv ====
`timescale 1ns/1ps
// Debug acknowledge and mode tracking
module rvfi_event_track #(
  parameter bit DEBUG = 1'b1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Retire strobe and kind of the retiring instruction
  input  logic                   accept_i,
  input  core_pkg::retire_kind_e wb_kind_i,

  // Level of dcsr.step
  input  logic                   step_i,

  // One-cycle debug entry acknowledge from the core
  input  logic                   dbg_ack_i,
  input  core_pkg::dbg_cause_e   dbg_cause_i,

  // Values for the record of the retiring instruction
  output core_pkg::dbg_cause_e   dbg_cause_o,
  output logic                   step_mark_o,
  output logic                   dbg_mode_o,

  // Debug mode as it was before this retire
  output logic                   in_dbg_mode_o
);

  import core_pkg::*;

  if (DEBUG) begin : gen_debug

    logic       dbg_pend_q;
    dbg_cause_e dbg_cause_q;
    logic       dbg_mode_q;
    logic       dbg_mode_d;

    //////////////////////////////////////////////////////////
    // Pending debug acknowledge
    //////////////////////////////////////////////////////////

    // The ack attaches to the next accepted retire
    // An ack at the same edge as an accept is kept for the one after
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        dbg_pend_q <= 1'b0;
      end else if (dbg_ack_i) begin
        dbg_pend_q <= 1'b1;
      end else if (accept_i) begin
        dbg_pend_q <= 1'b0;
      end
    end

    // Cause is only looked at while the pending flag is set
    always_ff @(posedge clk_i) begin
      if (dbg_ack_i) begin
        dbg_cause_q <= dbg_cause_i;
      end
    end

    assign dbg_cause_o = dbg_pend_q ? dbg_cause_q : DBG_NONE;

    //////////////////////////////////////////////////////////
    // Debug mode
    //////////////////////////////////////////////////////////

    // The record that carries the entry cause is already in debug mode
    assign dbg_mode_o = dbg_mode_q || dbg_pend_q;

    // DRET still retires in debug mode, the records after it do not
    assign dbg_mode_d = (wb_kind_i == RET_DRET) ? 1'b0 : dbg_mode_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        dbg_mode_q <= 1'b0;
      end else if (accept_i) begin
        dbg_mode_q <= dbg_mode_d;
      end
    end

    assign in_dbg_mode_o = dbg_mode_q;

    // Stepping has no effect while the hart sits in debug mode
    assign step_mark_o = step_i && !dbg_mode_q;

  end else begin : gen_no_debug

    // Debug support built out, the record fields read zero
    assign dbg_cause_o   = DBG_NONE;
    assign step_mark_o   = 1'b0;
    assign dbg_mode_o    = 1'b0;
    assign in_dbg_mode_o = 1'b0;

  end

endmodule

// ==== rvfi/rvfi_trap_track.sv ====
`timescale 1ns/1ps
// Trap history and mcause shadow
module rvfi_trap_track (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Retire strobe with kind and exception cause
  input  logic                             accept_i,
  input  core_pkg::retire_kind_e           wb_kind_i,
  input  logic [core_pkg::EXC_CAUSE_W-1:0] wb_exc_cause_i,

  // One-cycle interrupt acknowledge from the core
  input  logic                             irq_ack_i,
  input  logic [core_pkg::IRQ_ID_W-1:0]    irq_id_i,

  // Debug mode before this retire
  input  logic                             in_dbg_mode_i,

  // Values for the record of the retiring instruction
  output logic                             intr_o,
  output logic                             intr_irq_o,
  output logic [rvfi_pkg::INTR_CAUSE_W-1:0] intr_cause_o,
  output logic                             trap_o,
  output logic [rvfi_pkg::MCAUSE_W-1:0]    mcause_o
);

  import core_pkg::*;
  import rvfi_pkg::*;

  logic                   irq_pend_q;
  logic [IRQ_ID_W-1:0]    irq_id_q;
  logic                   exc_pend_q;
  logic [EXC_CAUSE_W-1:0] exc_cause_q;
  logic [MCAUSE_W-1:0]    mcause_q;
  logic [MCAUSE_W-1:0]    mcause_irq;
  logic [MCAUSE_W-1:0]    mcause_exc;

  ////////////////////////////////////////////////////////////
  // Pending interrupt and previous trap
  ////////////////////////////////////////////////////////////

  // Interrupt ack re-arms even when it lands on an accept edge
  // Exceptions retired in debug mode leave no trace for the next record
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pend_q <= 1'b0;
      exc_pend_q <= 1'b0;
      mcause_q   <= '0;
    end else begin
      if (irq_ack_i) begin
        irq_pend_q <= 1'b1;
      end else if (accept_i) begin
        irq_pend_q <= 1'b0;
      end
      if (accept_i) begin
        exc_pend_q <= trap_o && !in_dbg_mode_i;
        mcause_q   <= mcause_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (irq_ack_i) begin
      irq_id_q <= irq_id_i;
    end
    if (accept_i && trap_o) begin
      exc_cause_q <= wb_exc_cause_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Marks for this record
  ////////////////////////////////////////////////////////////

  assign trap_o     = (wb_kind_i == RET_EXCEPTION);
  assign intr_o     = irq_pend_q || exc_pend_q;
  assign intr_irq_o = irq_pend_q;

  // Interrupt entry takes priority over the trailing exception
  assign intr_cause_o = irq_pend_q ? INTR_CAUSE_W'(irq_id_q) : INTR_CAUSE_W'(exc_cause_q);

  // mcause values for the two kinds of handler entry
  always_comb begin
    mcause_irq                     = '0;
    mcause_irq[MCAUSE_IRQ_BIT]     = 1'b1;
    mcause_irq[IRQ_ID_W-1:0]       = irq_id_q;
  end

  assign mcause_exc = MCAUSE_W'(exc_cause_q);

  // Unchanged when no handler was entered before this retire
  assign mcause_o = irq_pend_q ? mcause_irq :
                    exc_pend_q ? mcause_exc : mcause_q;

endmodule

// ==== rvfi/rvfi_record_reg.sv ====
`timescale 1ns/1ps
// Trace record register
module rvfi_record_reg (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                accept_i,

  // Writeback payload
  input  logic [rvfi_pkg::PC_W-1:0]           wb_pc_i,
  input  logic [core_pkg::EXC_CAUSE_W-1:0]    wb_exc_cause_i,

  // From the trap tracker
  input  logic                                intr_i,
  input  logic                                intr_irq_i,
  input  logic [rvfi_pkg::INTR_CAUSE_W-1:0]   intr_cause_i,
  input  logic                                trap_i,
  input  logic [rvfi_pkg::MCAUSE_W-1:0]       mcause_i,

  // From the debug event tracker
  input  logic                                step_mark_i,
  input  core_pkg::dbg_cause_e                dbg_cause_i,
  input  logic                                dbg_mode_i,

  // Record towards the consumer
  output logic [rvfi_pkg::PC_W-1:0]           rvfi_pc_o,
  output logic                                rvfi_intr_o,
  output logic                                rvfi_intr_irq_o,
  output logic [rvfi_pkg::INTR_CAUSE_W-1:0]   rvfi_intr_cause_o,
  output logic                                rvfi_trap_o,
  output logic [core_pkg::EXC_CAUSE_W-1:0]    rvfi_trap_cause_o,
  output logic                                rvfi_trap_dbg_o,
  output core_pkg::dbg_cause_e                rvfi_dbg_o,
  output logic [rvfi_pkg::MCAUSE_W-1:0]       rvfi_mcause_o,
  output logic                                rvfi_dbg_mode_o
);

  import core_pkg::*;

  logic [EXC_CAUSE_W-1:0] trap_cause_d;

  // Exception cause wins, a plain step shows the step cause
  assign trap_cause_d = trap_i      ? wb_exc_cause_i :
                        step_mark_i ? EXC_CAUSE_W'(DBG_STEP) : '0;

  // Marks and mcause are cleared, so the idle record reads zero
  // Everything holds from accept until the next accept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_intr_o     <= 1'b0;
      rvfi_intr_irq_o <= 1'b0;
      rvfi_trap_o     <= 1'b0;
      rvfi_trap_dbg_o <= 1'b0;
      rvfi_dbg_o      <= DBG_NONE;
      rvfi_mcause_o   <= '0;
      rvfi_dbg_mode_o <= 1'b0;
    end else if (accept_i) begin
      rvfi_intr_o     <= intr_i;
      rvfi_intr_irq_o <= intr_irq_i;
      rvfi_trap_o     <= trap_i;
      rvfi_trap_dbg_o <= step_mark_i;
      rvfi_dbg_o      <= dbg_cause_i;
      rvfi_mcause_o   <= mcause_i;
      rvfi_dbg_mode_o <= dbg_mode_i;
    end
  end

  // Payload fields
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      rvfi_pc_o         <= wb_pc_i;
      rvfi_intr_cause_o <= intr_cause_i;
      rvfi_trap_cause_o <= trap_cause_d;
    end
  end

endmodule

// ==== verilog/rvfi_top.sv ====
`timescale 1ns/1ps
// Retirement trace unit
module rvfi_top #(
  parameter bit DEBUG = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Writeback stage of the core
  input  logic                                wb_valid_i,
  output logic                                wb_ready_o,
  input  logic [rvfi_pkg::PC_W-1:0]           wb_pc_i,
  input  core_pkg::retire_kind_e              wb_kind_i,
  input  logic [core_pkg::EXC_CAUSE_W-1:0]    wb_exc_cause_i,

  // Handler and debug entry acknowledges
  input  logic                                irq_ack_i,
  input  logic [core_pkg::IRQ_ID_W-1:0]       irq_id_i,
  input  logic                                dbg_ack_i,
  input  core_pkg::dbg_cause_e                dbg_cause_i,
  input  logic                                step_i,

  // Four-phase trace output
  output logic                                rvfi_req_o,
  input  logic                                rvfi_ack_i,
  output logic [rvfi_pkg::PC_W-1:0]           rvfi_pc_o,
  output logic                                rvfi_intr_o,
  output logic                                rvfi_intr_irq_o,
  output logic [rvfi_pkg::INTR_CAUSE_W-1:0]   rvfi_intr_cause_o,
  output logic                                rvfi_trap_o,
  output logic [core_pkg::EXC_CAUSE_W-1:0]    rvfi_trap_cause_o,
  output logic                                rvfi_trap_dbg_o,
  output core_pkg::dbg_cause_e                rvfi_dbg_o,
  output logic [rvfi_pkg::MCAUSE_W-1:0]       rvfi_mcause_o,
  output logic                                rvfi_dbg_mode_o
);

  import core_pkg::*;
  import rvfi_pkg::*;

  logic                    accept;
  logic                    step_mark;
  dbg_cause_e              dbg_cause;
  logic                    dbg_mode;
  logic                    in_dbg_mode;
  logic                    intr;
  logic                    intr_irq;
  logic [INTR_CAUSE_W-1:0] intr_cause;
  logic                    trap;
  logic [MCAUSE_W-1:0]     mcause;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  rvfi_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_valid_i (wb_valid_i),
    .wb_ready_o (wb_ready_o),
    .accept_o   (accept),
    .rvfi_req_o (rvfi_req_o),
    .rvfi_ack_i (rvfi_ack_i)
  );

  ////////////////////////////////////////////////////////////
  // Event tracking
  ////////////////////////////////////////////////////////////

  rvfi_event_track #(
    .DEBUG (DEBUG)
  ) u_event_track (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .wb_kind_i     (wb_kind_i),
    .step_i        (step_i),
    .dbg_ack_i     (dbg_ack_i),
    .dbg_cause_i   (dbg_cause_i),
    .dbg_cause_o   (dbg_cause),
    .step_mark_o   (step_mark),
    .dbg_mode_o    (dbg_mode),
    .in_dbg_mode_o (in_dbg_mode)
  );

  // Debug mode gates the trap history, so the mode comes in here
  rvfi_trap_track u_trap_track (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .accept_i       (accept),
    .wb_kind_i      (wb_kind_i),
    .wb_exc_cause_i (wb_exc_cause_i),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .in_dbg_mode_i  (in_dbg_mode),
    .intr_o         (intr),
    .intr_irq_o     (intr_irq),
    .intr_cause_o   (intr_cause),
    .trap_o         (trap),
    .mcause_o       (mcause)
  );

  ////////////////////////////////////////////////////////////
  // Record
  ////////////////////////////////////////////////////////////

  rvfi_record_reg u_record_reg (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .accept_i          (accept),
    .wb_pc_i           (wb_pc_i),
    .wb_exc_cause_i    (wb_exc_cause_i),
    .intr_i            (intr),
    .intr_irq_i        (intr_irq),
    .intr_cause_i      (intr_cause),
    .trap_i            (trap),
    .mcause_i          (mcause),
    .step_mark_i       (step_mark),
    .dbg_cause_i       (dbg_cause),
    .dbg_mode_i        (dbg_mode),
    .rvfi_pc_o         (rvfi_pc_o),
    .rvfi_intr_o       (rvfi_intr_o),
    .rvfi_intr_irq_o   (rvfi_intr_irq_o),
    .rvfi_intr_cause_o (rvfi_intr_cause_o),
    .rvfi_trap_o       (rvfi_trap_o),
    .rvfi_trap_cause_o (rvfi_trap_cause_o),
    .rvfi_trap_dbg_o   (rvfi_trap_dbg_o),
    .rvfi_dbg_o        (rvfi_dbg_o),
    .rvfi_mcause_o     (rvfi_mcause_o),
    .rvfi_dbg_mode_o   (rvfi_dbg_mode_o)
  );

endmodule

// ==== verif/rvfi_properties.sv ====
`timescale 1ns/1ps
// Trace unit assertions
module rvfi_properties (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                dbg_ack_i,
  input  logic                                rvfi_req_i,
  input  logic                                rvfi_ack_i,
  input  logic [rvfi_pkg::PC_W-1:0]           rvfi_pc_i,
  input  logic                                rvfi_intr_i,
  input  logic                                rvfi_intr_irq_i,
  input  logic [rvfi_pkg::INTR_CAUSE_W-1:0]   rvfi_intr_cause_i,
  input  logic                                rvfi_trap_i,
  input  logic [core_pkg::EXC_CAUSE_W-1:0]    rvfi_trap_cause_i,
  input  logic                                rvfi_trap_dbg_i,
  input  core_pkg::dbg_cause_e                rvfi_dbg_i,
  input  logic [rvfi_pkg::MCAUSE_W-1:0]       rvfi_mcause_i,
  input  logic                                rvfi_dbg_mode_i
);

  import core_pkg::*;
  import rvfi_pkg::*;

  // Width of the whole record as one flat vector
  localparam int REC_W = PC_W + INTR_CAUSE_W + EXC_CAUSE_W + DBG_CAUSE_W + MCAUSE_W + 5;

  logic             req_q;
  logic             rec_start;
  logic             prev_trap_q;
  logic             prev_step_q;
  logic [3:0]       dbg_ack_cnt_q;
  logic [REC_W-1:0] record;

  // Failed assertions, read by the testbench at the end of the run
  int assert_fails = 0;

  ////////////////////////////////////////////////////////////
  // Record history
  ////////////////////////////////////////////////////////////

  // First cycle of a new record on the consumer side
  assign rec_start = rvfi_req_i && !req_q;

  assign record = {rvfi_pc_i, rvfi_intr_i, rvfi_intr_irq_i, rvfi_intr_cause_i, rvfi_trap_i,
                   rvfi_trap_cause_i, rvfi_trap_dbg_i, rvfi_dbg_i, rvfi_mcause_i,
                   rvfi_dbg_mode_i};

  // Traps taken in debug mode enter no handler, so they are not remembered
  // The ack counter goes up per debug ack and down per record with a cause
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q         <= 1'b0;
      prev_trap_q   <= 1'b0;
      prev_step_q   <= 1'b0;
      dbg_ack_cnt_q <= '0;
    end else begin
      req_q <= rvfi_req_i;
      if (rec_start) begin
        prev_trap_q <= rvfi_trap_i && !rvfi_dbg_mode_i;
        prev_step_q <= rvfi_trap_dbg_i;
      end
      dbg_ack_cnt_q <= dbg_ack_cnt_q + 4'(dbg_ack_i)
                       - 4'(rec_start && (rvfi_dbg_i != DBG_NONE));
    end
  end

  ////////////////////////////////////////////////////////////
  // Record rules
  ////////////////////////////////////////////////////////////

  // Handler entry after a trap shows up on the very next record
  trap_then_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_start && prev_trap_q |-> rvfi_intr_i)
    else begin
      assert_fails++;
      $error("Trap record not followed by an interrupt mark");
    end

  // A stepped instruction is followed by the step debug entry
  step_then_dbg: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_start && prev_step_q |-> rvfi_dbg_i == DBG_STEP)
    else begin
      assert_fails++;
      $error("Step mark not followed by a step debug entry");
    end

  // No debug cause without an ack from the core
  dbg_needs_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_start && rvfi_dbg_i != DBG_NONE |-> dbg_ack_cnt_q != 0)
    else begin
      assert_fails++;
      $error("Debug cause on a record without a preceding debug ack");
    end

  ////////////////////////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////////////////////////

  record_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_req_i |=> $stable(record))
    else begin
      assert_fails++;
      $error("Record changed while req was high");
    end

  req_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_req_i && !rvfi_ack_i |=> rvfi_req_i)
    else begin
      assert_fails++;
      $error("Req dropped before ack");
    end

endmodule

bind rvfi_top rvfi_properties u_properties (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .dbg_ack_i         (dbg_ack_i),
  .rvfi_req_i        (rvfi_req_o),
  .rvfi_ack_i        (rvfi_ack_i),
  .rvfi_pc_i         (rvfi_pc_o),
  .rvfi_intr_i       (rvfi_intr_o),
  .rvfi_intr_irq_i   (rvfi_intr_irq_o),
  .rvfi_intr_cause_i (rvfi_intr_cause_o),
  .rvfi_trap_i       (rvfi_trap_o),
  .rvfi_trap_cause_i (rvfi_trap_cause_o),
  .rvfi_trap_dbg_i   (rvfi_trap_dbg_o),
  .rvfi_dbg_i        (rvfi_dbg_o),
  .rvfi_mcause_i     (rvfi_mcause_o),
  .rvfi_dbg_mode_i   (rvfi_dbg_mode_o)
);

// ==== verif/tb_rvfi.sv ====
`timescale 1ns/1ps
// Trace unit testbench
module tb_rvfi;

  import core_pkg::*;
  import rvfi_pkg::*;

  localparam int NUM_STEPS = 27;
  localparam int NUM_COLS  = 17;
  localparam int TIMEOUT   = 50;

  // Columns of one trace line, stimulus first
  localparam int C_IRQ_ACK    = 0;
  localparam int C_IRQ_ID     = 1;
  localparam int C_DBG_ACK    = 2;
  localparam int C_DBG_CAUSE  = 3;
  localparam int C_STEP       = 4;
  localparam int C_KIND       = 5;
  localparam int C_PC         = 6;
  localparam int C_EXC        = 7;
  localparam int C_INTR       = 8;
  localparam int C_INTR_IRQ   = 9;
  localparam int C_INTR_CAUSE = 10;
  localparam int C_TRAP       = 11;
  localparam int C_TRAP_CAUSE = 12;
  localparam int C_TRAP_DBG   = 13;
  localparam int C_DBG        = 14;
  localparam int C_MCAUSE     = 15;
  localparam int C_DBG_MODE   = 16;

  // Selectors for the wait loop
  localparam int SEL_READY = 0;
  localparam int SEL_REQ   = 1;

  logic                    clk;
  logic                    rst_n;
  logic                    wb_valid;
  logic                    wb_ready;
  logic [PC_W-1:0]         wb_pc;
  retire_kind_e            wb_kind;
  logic [EXC_CAUSE_W-1:0]  wb_exc_cause;
  logic                    irq_ack;
  logic [IRQ_ID_W-1:0]     irq_id;
  logic                    dbg_ack;
  dbg_cause_e              dbg_cause;
  logic                    step;
  logic                    rvfi_req;
  logic                    rvfi_ack;
  logic [PC_W-1:0]         rvfi_pc;
  logic                    rvfi_intr;
  logic                    rvfi_intr_irq;
  logic [INTR_CAUSE_W-1:0] rvfi_intr_cause;
  logic                    rvfi_trap;
  logic [EXC_CAUSE_W-1:0]  rvfi_trap_cause;
  logic                    rvfi_trap_dbg;
  dbg_cause_e              rvfi_dbg;
  logic [MCAUSE_W-1:0]     rvfi_mcause;
  logic                    rvfi_dbg_mode;

  logic [31:0] trace_mem [0:NUM_STEPS*NUM_COLS-1];
  int          errors    = 0;
  int          timeouts  = 0;
  int          records   = 0;
  bit          timed_out = 1'b0;
  logic        req_prev  = 1'b0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  rvfi_top #(
    .DEBUG (1'b1)
  ) dut_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .wb_valid_i        (wb_valid),
    .wb_ready_o        (wb_ready),
    .wb_pc_i           (wb_pc),
    .wb_kind_i         (wb_kind),
    .wb_exc_cause_i    (wb_exc_cause),
    .irq_ack_i         (irq_ack),
    .irq_id_i          (irq_id),
    .dbg_ack_i         (dbg_ack),
    .dbg_cause_i       (dbg_cause),
    .step_i            (step),
    .rvfi_req_o        (rvfi_req),
    .rvfi_ack_i        (rvfi_ack),
    .rvfi_pc_o         (rvfi_pc),
    .rvfi_intr_o       (rvfi_intr),
    .rvfi_intr_irq_o   (rvfi_intr_irq),
    .rvfi_intr_cause_o (rvfi_intr_cause),
    .rvfi_trap_o       (rvfi_trap),
    .rvfi_trap_cause_o (rvfi_trap_cause),
    .rvfi_trap_dbg_o   (rvfi_trap_dbg),
    .rvfi_dbg_o        (rvfi_dbg),
    .rvfi_mcause_o     (rvfi_mcause),
    .rvfi_dbg_mode_o   (rvfi_dbg_mode)
  );

  ////////////////////////////////////////////////////////////
  // Handshake monitor
  ////////////////////////////////////////////////////////////

  // The core must see back-pressure for as long as an exchange is open
  // Every rising req is one record, which catches lost or doubled records
  always @(negedge clk) begin
    if (rst_n) begin
      if ((rvfi_req || rvfi_ack) && wb_ready) begin
        errors++;
        $display("** Error at %0t: wb_ready_o = 1, expected 0", $time);
      end
      if (rvfi_req && !req_prev) begin
        records++;
      end
    end
    req_prev = rvfi_req;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] field(input int step_idx, input int col);
    return trace_mem[step_idx*NUM_COLS + col];
  endfunction

  function automatic logic probe(input int sel);
    return (sel == SEL_READY) ? wb_ready : rvfi_req;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Polls at the falling edge, where DUT outputs have settled
  task automatic wait_level(input int sel, input logic level, input string name);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      if (probe(sel) === level) begin
        seen = 1'b1;
      end
      cycles++;
    end
    if (!seen) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout at %0t: %s did not reach %0b within %0d cycles",
               $time, name, level, TIMEOUT);
    end
  endtask

  task automatic check_record(input int i);
    compare_field("rvfi_pc_o", rvfi_pc, field(i, C_PC));
    compare_field("rvfi_intr_o", rvfi_intr, field(i, C_INTR));
    compare_field("rvfi_intr_irq_o", rvfi_intr_irq, field(i, C_INTR_IRQ));
    // The cause only means something when the mark is set
    if (field(i, C_INTR) == 1) begin
      compare_field("rvfi_intr_cause_o", rvfi_intr_cause, field(i, C_INTR_CAUSE));
    end
    compare_field("rvfi_trap_o", rvfi_trap, field(i, C_TRAP));
    compare_field("rvfi_trap_cause_o", rvfi_trap_cause, field(i, C_TRAP_CAUSE));
    compare_field("rvfi_trap_dbg_o", rvfi_trap_dbg, field(i, C_TRAP_DBG));
    compare_field("rvfi_dbg_o", rvfi_dbg, field(i, C_DBG));
    compare_field("rvfi_mcause_o", rvfi_mcause, field(i, C_MCAUSE));
    compare_field("rvfi_dbg_mode_o", rvfi_dbg_mode, field(i, C_DBG_MODE));
  endtask

  // One trace line: acks, retire, record check and the consumer side
  task automatic run_step(input int i);
    int delay;
    wait_level(SEL_READY, 1'b1, "wb_ready_o");
    if (timed_out) return;
    @(posedge clk);
    // Acks of kind 1 land one cycle ahead of the retire
    if (field(i, C_IRQ_ACK) == 1 || field(i, C_DBG_ACK) == 1) begin
      irq_ack   <= (field(i, C_IRQ_ACK) == 1);
      irq_id    <= IRQ_ID_W'(field(i, C_IRQ_ID));
      dbg_ack   <= (field(i, C_DBG_ACK) == 1);
      dbg_cause <= dbg_cause_e'(DBG_CAUSE_W'(field(i, C_DBG_CAUSE)));
      @(posedge clk);
    end
    // Acks of kind 2 are sampled on the accept edge itself
    irq_ack      <= (field(i, C_IRQ_ACK) == 2);
    irq_id       <= IRQ_ID_W'(field(i, C_IRQ_ID));
    dbg_ack      <= (field(i, C_DBG_ACK) == 2);
    dbg_cause    <= dbg_cause_e'(DBG_CAUSE_W'(field(i, C_DBG_CAUSE)));
    step         <= (field(i, C_STEP) != 0);
    wb_valid     <= 1'b1;
    wb_pc        <= field(i, C_PC);
    wb_kind      <= retire_kind_e'(2'(field(i, C_KIND)));
    wb_exc_cause <= EXC_CAUSE_W'(field(i, C_EXC));
    @(posedge clk);
    wb_valid <= 1'b0;
    irq_ack  <= 1'b0;
    dbg_ack  <= 1'b0;
    wait_level(SEL_REQ, 1'b1, "rvfi_req_o");
    if (timed_out) return;
    check_record(i);
    // Consumer takes 0 to 3 extra cycles before it acks
    delay = $urandom % 4;
    repeat (delay) @(posedge clk);
    @(posedge clk);
    rvfi_ack <= 1'b1;
    wait_level(SEL_REQ, 1'b0, "rvfi_req_o");
    if (timed_out) return;
    @(posedge clk);
    rvfi_ack <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'he904));
    rst_n        = 1'b0;
    wb_valid     = 1'b0;
    wb_pc        = '0;
    wb_kind      = RET_NORMAL;
    wb_exc_cause = '0;
    irq_ack      = 1'b0;
    irq_id       = '0;
    dbg_ack      = 1'b0;
    dbg_cause    = DBG_NONE;
    step         = 1'b0;
    rvfi_ack     = 1'b0;
    $readmemh("verif/rvfi_trace.txt", trace_mem);
    if ($isunknown(trace_mem[NUM_STEPS*NUM_COLS-1])) begin
      errors++;
      $display("Trace file holds fewer lines than the %0d steps expected", NUM_STEPS);
    end
    @(negedge clk);
    compare_field("rvfi_req_o", rvfi_req, 32'd0);
    compare_field("wb_ready_o", wb_ready, 32'd1);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_field("rvfi_mcause_o", rvfi_mcause, 32'd0);
    compare_field("rvfi_dbg_mode_o", rvfi_dbg_mode, 32'd0);
    for (int i = 0; i < NUM_STEPS && !timed_out; i++) begin
      run_step(i);
    end
    if (!timed_out && records != NUM_STEPS) begin
      errors++;
      $display("Consumer saw %0d records but the trace has %0d", records, NUM_STEPS);
    end
    errors += dut_i.u_properties.assert_fails;
    $display("Run done: %0d errors, %0d timeouts, %0d assertion failures, %0d records",
             errors, timeouts, dut_i.u_properties.assert_fails, records);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/rvfi_trace.txt ====
// irq_ack irq_id dbg_ack dbg_cause step kind pc exc_cause  (ack 1 = before retire, 2 = with it)
// intr intr_irq intr_cause trap trap_cause trap_dbg dbg mcause dbg_mode  (expected record)
0 00 0 0 0 0 00000100 00   0 0 000 0 00 0 0 00000000 0
0 00 0 0 0 1 00000104 02   0 0 000 1 02 0 0 00000000 0
0 00 0 0 0 0 00000800 00   1 0 002 0 00 0 0 00000002 0
0 00 0 0 0 0 00000804 00   0 0 000 0 00 0 0 00000002 0
1 07 0 0 0 0 00000808 00   1 1 007 0 00 0 0 80000007 0
2 0b 0 0 0 0 00000900 00   0 0 000 0 00 0 0 80000007 0
0 00 0 0 0 0 00000904 00   1 1 00b 0 00 0 0 8000000b 0
0 00 0 0 0 1 00000908 05   0 0 000 1 05 0 0 8000000b 0
1 03 0 0 0 0 00000a00 00   1 1 003 0 00 0 0 80000003 0
0 00 0 0 0 1 00000a04 0b   0 0 000 1 0b 0 0 80000003 0
0 00 0 0 0 1 00000b00 01   1 0 00b 1 01 0 0 0000000b 0
0 00 0 0 0 0 00000c00 00   1 0 001 0 00 0 0 00000001 0
0 00 1 3 0 0 00000c04 00   0 0 000 0 00 0 3 00000001 1
0 00 0 0 0 1 00001000 03   0 0 000 1 03 0 0 00000001 1
0 00 0 0 0 2 00001004 00   0 0 000 0 00 0 0 00000001 1
0 00 0 0 0 0 00000c08 00   0 0 000 0 00 0 0 00000001 0
0 00 0 0 1 0 00000c0c 00   0 0 000 0 04 1 0 00000001 0
0 00 1 4 0 0 00001000 00   0 0 000 0 00 0 4 00000001 1
0 00 0 0 1 0 00001004 00   0 0 000 0 00 0 0 00000001 1
0 00 0 0 1 2 00001008 00   0 0 000 0 00 0 0 00000001 1
0 00 0 0 1 1 00000c10 02   0 0 000 1 02 1 0 00000001 0
0 00 1 4 0 0 00001000 00   1 0 002 0 00 0 4 00000002 1
0 00 0 0 0 2 00001004 00   0 0 000 0 00 0 0 00000002 1
0 00 2 1 0 0 00000c14 00   0 0 000 0 00 0 0 00000002 0
0 00 0 0 0 0 00001000 00   0 0 000 0 00 0 1 00000002 1
0 00 0 0 0 2 00001004 00   0 0 000 0 00 0 0 00000002 1
0 00 0 0 0 0 00000c18 00   0 0 000 0 00 0 0 00000002 0

// ==== src.f ====
common/core_pkg.sv
common/rvfi_pkg.sv
rvfi/rvfi_ctrl.sv
rvfi/rvfi_event_track.sv
rvfi/rvfi_trap_track.sv
rvfi/rvfi_record_reg.sv
verilog/rvfi_top.sv
verif/rvfi_properties.sv
verif/tb_rvfi.sv

// ==== Bender.yml ====
package:
  name: rvfi_trace

sources:
  # Shared packages
  - common/core_pkg.sv
  - common/rvfi_pkg.sv
  # Trace unit
  - rvfi/rvfi_ctrl.sv
  - rvfi/rvfi_event_track.sv
  - rvfi/rvfi_trap_track.sv
  - rvfi/rvfi_record_reg.sv
  - verilog/rvfi_top.sv
  # Verification
  - target: simulation
    files:
      - verif/rvfi_properties.sv
      - verif/tb_rvfi.sv
